// ==== hw/sl_pkg.sv ====
// shared widths, thresholds and bus types for the scanline pipeline; compile before all other files
`default_nettype none

package sl_pkg;

  //////////////////////////////
  // widths and pipeline depth
  //////////////////////////////

  localparam int COLOR_W      = 8;           // bits per color channel
  localparam int REF_W        = COLOR_W + 1; // reference carries one extra bit
  localparam int PROC_STAGES  = 10;          // input to output latency
  localparam int BLOOM_CALC_W = 8;           // fixed, matches 8 bit strength

  //////////////////////////////
  // scanline geometry
  //////////////////////////////

  // positions are fractions of the half line, 8'h80 == 0.5
  localparam logic [7:0] PROFILE_WIDTH = 8'd64;  // ramp length of the profile
  localparam logic [7:0] VAL_THIN      = 8'd48;  // 0.1875
  localparam logic [7:0] VAL_NORMAL    = 8'd32;  // 0.125
  localparam logic [7:0] VAL_THICK     = 8'd16;  // 0.0625
  localparam logic [7:0] FOLD_HALF     = 8'd128; // fold point of the position

  //////////////////////////////
  // types
  //////////////////////////////

  typedef enum logic [1:0] {
    SL_ADAPTIVE = 2'd0, // threshold follows the reference level
    SL_THIN     = 2'd1,
    SL_NORMAL   = 2'd2,
    SL_THICK    = 2'd3
  } sl_thick_e;

  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } pix_t;

  // per channel reference, 0..510
  typedef struct packed {
    logic [REF_W-1:0] r;
    logic [REF_W-1:0] g;
    logic [REF_W-1:0] b;
  } ref_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } vsync_t;

  // static configuration, expected stable while video runs
  typedef struct packed {
    logic       en;          // scanlines on
    logic       per_channel; // 1: per channel reference, 0: luma
    sl_thick_e  thickness;
    logic [7:0] rel_pos;     // position inside the line pair
    logic [7:0] strength;
    logic [4:0] bloom;       // reduction of strength on bright pixels
  } sl_cfg_t;

endpackage

`default_nettype wire

// ==== hw/sl_timing_ctrl.sv ====
// sync and pixel delay line, position fold and the final draw or pass select of the scanline stage
`default_nettype none

module sl_timing_ctrl (
  input  wire                 VCLK_i,
  input  wire                 nVRST_i,
  input  wire sl_pkg::vsync_t sync_i,
  input  wire sl_pkg::pix_t   pix_i,
  input  wire [7:0]           rel_pos_i,
  input  wire sl_pkg::pix_t   sl_pix_i,  // scanlined pixel, stage 8
  input  wire [2:0]           draw_i,    // {r,g,b}, stage 8
  output logic [7:0]          fold_pos_o,
  output sl_pkg::pix_t        pix_d7_o,
  output sl_pkg::vsync_t      sync_o,
  output sl_pkg::pix_t        pix_o
);

  import sl_pkg::*;

  vsync_t     sync_l [PROC_STAGES-1]; // index == pipeline stage
  pix_t       pix_l  [PROC_STAGES-1];
  logic [7:0] fold_l0;

  //////////////////////////////
  // delay line, stages 0..8
  //////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      for (int i = 0; i < PROC_STAGES-1; i++) begin
        sync_l[i] <= '0;
        pix_l[i]  <= '0;
      end
    end else begin
      sync_l[0] <= sync_i;
      pix_l[0]  <= pix_i;
      for (int i = 1; i < PROC_STAGES-1; i++) begin
        sync_l[i] <= sync_l[i-1];
        pix_l[i]  <= pix_l[i-1];
      end
    end
  end

  assign pix_d7_o = pix_l[PROC_STAGES-3]; // feeds the final multiply

  // fold position into 0..0.5 of the line pair
  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      fold_l0    <= '0;
      fold_pos_o <= '0;
    end else begin
      fold_l0    <= (rel_pos_i > FOLD_HALF) ? 8'd0 - rel_pos_i : rel_pos_i; // stage 0
      fold_pos_o <= fold_l0; // stage 1, reference ready
    end
  end

  //////////////////////////////
  // output select, stage 9
  //////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      sync_o <= '0;
      pix_o  <= '0;
    end else begin
      sync_o <= sync_l[PROC_STAGES-2];
      // blanking always passes the original
      pix_o.r <= (sync_l[PROC_STAGES-2].de && draw_i[2]) ? sl_pix_i.r : pix_l[PROC_STAGES-2].r;
      pix_o.g <= (sync_l[PROC_STAGES-2].de && draw_i[1]) ? sl_pix_i.g : pix_l[PROC_STAGES-2].g;
      pix_o.b <= (sync_l[PROC_STAGES-2].de && draw_i[0]) ? sl_pix_i.b : pix_l[PROC_STAGES-2].b;
    end
  end

endmodule

`default_nettype wire

// ==== hw/sl_ref_gen.sv ====
// reference level per channel or from luma, plus the bloom pre-scaled reference for all channels
`default_nettype none

module sl_ref_gen (
  input  wire               VCLK_i,
  input  wire               nVRST_i,
  input  wire sl_pkg::pix_t pix_i,
  input  wire               per_channel_i,
  input  wire [4:0]         bloom_i,
  output sl_pkg::ref_t      ref_o,       // stage 1
  output sl_pkg::ref_t      bloom_ref_o  // stage 4
);

  import sl_pkg::*;

  pix_t             pix_l0;
  logic [COLOR_W:0] rpb_l0;   // r + b
  logic [REF_W-1:0] luma_w;
  ref_t             ref_l2;
  ref_t             bref_l3;
  logic [REF_W+4:0] bprod_r_w;
  logic [REF_W+4:0] bprod_g_w;
  logic [REF_W+4:0] bprod_b_w;

  // approx. luma, g + (r+b)/2
  assign luma_w = {1'b0, pix_l0.g} + {1'b0, rpb_l0[COLOR_W:1]};

  // bloom is a 5 bit fraction of the reference
  assign bprod_r_w = ref_l2.r * bloom_i;
  assign bprod_g_w = ref_l2.g * bloom_i;
  assign bprod_b_w = ref_l2.b * bloom_i;

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      pix_l0      <= '0;
      rpb_l0      <= '0;
      ref_o       <= '0;
      ref_l2      <= '0;
      bref_l3     <= '0;
      bloom_ref_o <= '0;
    end else begin
      pix_l0 <= pix_i;
      rpb_l0 <= {1'b0, pix_i.r} + {1'b0, pix_i.b}; // stage 0

      if (per_channel_i) begin
        ref_o.r <= {pix_l0.r, 1'b0};
        ref_o.g <= {pix_l0.g, 1'b0};
        ref_o.b <= {pix_l0.b, 1'b0};
      end else begin
        ref_o.r <= luma_w;
        ref_o.g <= luma_w;
        ref_o.b <= luma_w;
      end

      ref_l2 <= ref_o; // stage 2

      bref_l3.r <= bprod_r_w[REF_W+4:5]; // stage 3
      bref_l3.g <= bprod_g_w[REF_W+4:5];
      bref_l3.b <= bprod_b_w[REF_W+4:5];

      bloom_ref_o <= bref_l3; // wait for strength, stage 4
    end
  end

endmodule

`default_nettype wire

// ==== hw/sl_strength_shaper.sv ====
// one channel of the scanline strength path: threshold, draw flag, rectangular profile and strength
`default_nettype none

module sl_strength_shaper (
  input  wire                    VCLK_i,
  input  wire                    nVRST_i,
  input  wire [7:0]              fold_pos_i,  // stage 1
  input  wire [sl_pkg::REF_W-1:0] ref_i,      // stage 1
  input  wire                    en_i,
  input  wire sl_pkg::sl_thick_e thickness_i,
  input  wire [7:0]              strength_i,
  output logic                   draw_o,      // stage 3
  output logic [7:0]             str_o        // stage 5
);

  import sl_pkg::*;

  logic [7:0]  thr_w;
  logic        draw_l2;
  logic        max_l2;
  logic        max_l3;
  logic [5:0]  ofs_l2;     // position inside the profile ramp
  logic [7:0]  prof_l3;
  logic [7:0]  str_l4;
  logic [15:0] str_full_w;

  //////////////////////////////
  // threshold
  //////////////////////////////

  always_comb begin
    case (thickness_i)
      SL_THIN:   thr_w = VAL_THIN;
      SL_NORMAL: thr_w = VAL_NORMAL;
      SL_THICK:  thr_w = VAL_THICK;
      // adaptive, 0 for black up to 0.25 for full white
      default:   thr_w = {2'b00, ref_i[REF_W-1:REF_W-6]} + {7'd0, ref_i[REF_W-7]};
    endcase
  end

  assign str_full_w = prof_l3 * strength_i;

  //////////////////////////////
  // flags and profile
  //////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      draw_l2 <= 1'b0;
      max_l2  <= 1'b0;
      ofs_l2  <= '0;
      draw_o  <= 1'b0;
      max_l3  <= 1'b0;
      prof_l3 <= '0;
      str_l4  <= '0;
      str_o   <= '0;
    end else begin
      draw_l2 <= en_i && (fold_pos_i > thr_w);             // stage 2
      max_l2  <= fold_pos_i >= thr_w + PROFILE_WIDTH;      // past the ramp
      ofs_l2  <= 6'(fold_pos_i - thr_w);

      draw_o  <= draw_l2;                                  // stage 3
      max_l3  <= max_l2;
      prof_l3 <= {ofs_l2, ofs_l2[5:4]};                    // rectangular ramp, 6 to 8 bit

      // saturate once the ramp is done
      str_l4 <= max_l3 ? strength_i : str_full_w[15:8];    // stage 4
      str_o  <= str_l4;                                    // stage 5
    end
  end

endmodule

`default_nettype wire

// ==== hw/sl_bloom_mix.sv ====
// one channel of the scanline output path: bloom reduction of the strength and pixel darkening
`default_nettype none

module sl_bloom_mix (
  input  wire                        VCLK_i,
  input  wire                        nVRST_i,
  input  wire [sl_pkg::REF_W-1:0]    bloom_ref_i, // stage 4
  input  wire [7:0]                  str_i,       // stage 5
  input  wire                        draw_i,      // stage 3
  input  wire [sl_pkg::COLOR_W-1:0]  pix_i,       // stage 7
  output logic [sl_pkg::COLOR_W-1:0] sl_pix_o,    // stage 8
  output logic                       draw_o       // stage 8
);

  import sl_pkg::*;

  logic [REF_W-1:0]                bref_l5;
  logic [REF_W+BLOOM_CALC_W-1:0]   bloomed_full_w;
  logic [REF_W-1:0]                bloomed_w;
  logic [BLOOM_CALC_W-1:0]         red_l6;   // strength after bloom
  logic [BLOOM_CALC_W-1:0]         inv_l7;   // pixel gain
  logic [COLOR_W+BLOOM_CALC_W-1:0] pix_full_w;
  logic [PROC_STAGES-2:4]          draw_l;   // index == stage

  //////////////////////////////
  // bloom reduction
  //////////////////////////////

  // bright reference eats into the strength
  assign bloomed_full_w = bref_l5 * str_i;
  assign bloomed_w      = bloomed_full_w[REF_W+BLOOM_CALC_W-1:BLOOM_CALC_W];

  assign pix_full_w = pix_i * inv_l7;

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      bref_l5  <= '0;
      red_l6   <= '0;
      inv_l7   <= '0;
      sl_pix_o <= '0;
    end else begin
      bref_l5 <= bloom_ref_i; // stage 5, aligned with str_i

      if ({1'b0, str_i} < bloomed_w)
        red_l6 <= '0;         // bloom cancels the scanline
      else
        red_l6 <= str_i - bloomed_w[BLOOM_CALC_W-1:0];

      inv_l7   <= {BLOOM_CALC_W{1'b1}} - red_l6;                    // stage 7
      sl_pix_o <= pix_full_w[COLOR_W+BLOOM_CALC_W-1:BLOOM_CALC_W];  // stage 8
    end
  end

  //////////////////////////////
  // draw flag, stages 4..8
  //////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      draw_l <= '0;
    end else begin
      draw_l[4] <= draw_i;
      for (int i = 5; i <= PROC_STAGES-2; i++) begin
        draw_l[i] <= draw_l[i-1];
      end
    end
  end

  assign draw_o = draw_l[PROC_STAGES-2];

endmodule

`default_nettype wire

// ==== hw/scanline_emu_top.sv ====
// scanline emulation top; streams RGB video with sync and DE and returns it 10 clocks later
`default_nettype none

module scanline_emu_top (
  input  wire                  VCLK_i,
  input  wire                  nVRST_i,
  input  wire sl_pkg::vsync_t  sync_i,
  input  wire sl_pkg::pix_t    pix_i,
  input  wire sl_pkg::sl_cfg_t cfg_i,
  output sl_pkg::vsync_t       sync_o,
  output sl_pkg::pix_t         pix_o
);

  import sl_pkg::*;

  logic [7:0] fold_pos_w;  // stage 1
  pix_t       pix_d7_w;    // stage 7
  ref_t       ref_w;       // stage 1
  ref_t       bloom_ref_w; // stage 4
  logic [2:0] draw_s3_w;   // {r,g,b}, stage 3
  logic [2:0] draw_s8_w;   // {r,g,b}, stage 8
  logic [7:0] str_r_w;
  logic [7:0] str_g_w;
  logic [7:0] str_b_w;
  pix_t       sl_pix_w;    // stage 8

  //////////////////////////////
  // sync, pixel delay, output
  //////////////////////////////

  sl_timing_ctrl u_ctrl (
    .VCLK_i, .nVRST_i,
    .sync_i,
    .pix_i,
    .rel_pos_i  (cfg_i.rel_pos),
    .sl_pix_i   (sl_pix_w),
    .draw_i     (draw_s8_w),
    .fold_pos_o (fold_pos_w),
    .pix_d7_o   (pix_d7_w),
    .sync_o,
    .pix_o
  );

  sl_ref_gen u_ref (
    .VCLK_i, .nVRST_i,
    .pix_i,
    .per_channel_i (cfg_i.per_channel),
    .bloom_i       (cfg_i.bloom),
    .ref_o         (ref_w),
    .bloom_ref_o   (bloom_ref_w)
  );

  //////////////////////////////
  // per channel slices
  //////////////////////////////

  sl_strength_shaper u_shape_r (
    .VCLK_i, .nVRST_i,
    .fold_pos_i  (fold_pos_w),
    .ref_i       (ref_w.r),
    .en_i        (cfg_i.en),
    .thickness_i (cfg_i.thickness),
    .strength_i  (cfg_i.strength),
    .draw_o      (draw_s3_w[2]),
    .str_o       (str_r_w)
  );

  sl_strength_shaper u_shape_g (
    .VCLK_i, .nVRST_i,
    .fold_pos_i  (fold_pos_w),
    .ref_i       (ref_w.g),
    .en_i        (cfg_i.en),
    .thickness_i (cfg_i.thickness),
    .strength_i  (cfg_i.strength),
    .draw_o      (draw_s3_w[1]),
    .str_o       (str_g_w)
  );

  sl_strength_shaper u_shape_b (
    .VCLK_i, .nVRST_i,
    .fold_pos_i  (fold_pos_w),
    .ref_i       (ref_w.b),
    .en_i        (cfg_i.en),
    .thickness_i (cfg_i.thickness),
    .strength_i  (cfg_i.strength),
    .draw_o      (draw_s3_w[0]),
    .str_o       (str_b_w)
  );

  sl_bloom_mix u_mix_r (
    .VCLK_i, .nVRST_i,
    .bloom_ref_i (bloom_ref_w.r),
    .str_i       (str_r_w),
    .draw_i      (draw_s3_w[2]),
    .pix_i       (pix_d7_w.r),
    .sl_pix_o    (sl_pix_w.r),
    .draw_o      (draw_s8_w[2])
  );

  sl_bloom_mix u_mix_g (
    .VCLK_i, .nVRST_i,
    .bloom_ref_i (bloom_ref_w.g),
    .str_i       (str_g_w),
    .draw_i      (draw_s3_w[1]),
    .pix_i       (pix_d7_w.g),
    .sl_pix_o    (sl_pix_w.g),
    .draw_o      (draw_s8_w[1])
  );

  sl_bloom_mix u_mix_b (
    .VCLK_i, .nVRST_i,
    .bloom_ref_i (bloom_ref_w.b),
    .str_i       (str_b_w),
    .draw_i      (draw_s3_w[0]),
    .pix_i       (pix_d7_w.b),
    .sl_pix_o    (sl_pix_w.b),
    .draw_o      (draw_s8_w[0])
  );

endmodule

`default_nettype wire

// ==== test/tb_model.svh ====
// reference model of the scanline stage and typed compare tasks; included inside the testbench module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// reference model
//////////////////////////////

// position folded into 0..128
function automatic int fold_position(input int pos);
  return (pos > 128) ? 256 - pos : pos;
endfunction

function automatic int pick_threshold(input sl_thick_e mode, input int ref_val);
  case (mode)
    SL_THIN:   return int'(VAL_THIN);
    SL_NORMAL: return int'(VAL_NORMAL);
    SL_THICK:  return int'(VAL_THICK);
    default:   return (ref_val >> 3) + ((ref_val >> 2) & 1); // top 6 bits, rounded
  endcase
endfunction

// one channel, from reference level to final output value
function automatic logic [7:0] shade_channel(input int pix_val, input int ref_val, input int fold,
                                             input vsync_t s, input sl_cfg_t c);
  int t;
  int ofs;
  int prof;
  int str;
  int bref;
  int bloomed;
  int red;
  bit draw;
  bit at_max;
  t    = pick_threshold(c.thickness, ref_val);
  draw = c.en && (fold > t);
  if (!(s.de && draw))
    return 8'(pix_val); // blanking or no scanline here
  at_max  = fold >= t + 64;
  ofs     = (fold - t) & 63;
  prof    = (ofs << 2) | (ofs >> 4);
  str     = at_max ? int'(c.strength) : (prof * int'(c.strength)) >> 8;
  bref    = (ref_val * int'(c.bloom)) >> 5;
  bloomed = (bref * str) >> 8;
  red     = (str < bloomed) ? 0 : str - bloomed;
  return 8'((pix_val * (255 - red)) >> 8);
endfunction

function automatic pix_t expect_pix(input pix_t p, input vsync_t s, input sl_cfg_t c);
  int   fold;
  int   luma;
  pix_t e;
  fold = fold_position(int'(c.rel_pos));
  luma = int'(p.g) + (int'(p.r) + int'(p.b)) / 2;
  if (c.per_channel) begin
    e.r = shade_channel(int'(p.r), 2 * int'(p.r), fold, s, c);
    e.g = shade_channel(int'(p.g), 2 * int'(p.g), fold, s, c);
    e.b = shade_channel(int'(p.b), 2 * int'(p.b), fold, s, c);
  end else begin
    e.r = shade_channel(int'(p.r), luma, fold, s, c);
    e.g = shade_channel(int'(p.g), luma, fold, s, c);
    e.b = shade_channel(int'(p.b), luma, fold, s, c);
  end
  return e;
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic check_sync(input string name, input vsync_t got, input vsync_t exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
    stop_on_failure();
  end
endtask

task automatic check_pix(input string name, input pix_t got, input pix_t exp);
  if (got !== exp) begin
    $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    stop_on_failure();
  end
endtask

`endif

// ==== test/tb_scanline_emu.sv ====
// testbench for the scanline stage; random video blocks against a model, run as the simulation top
`default_nettype none

module tb_scanline_emu;

  import sl_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 4;
  localparam int ACT_LEN         = 48;  // random video per block
  localparam int FLUSH_LEN       = 12;  // DE low before the next cfg
  localparam int BLOCK_LEN       = ACT_LEN + FLUSH_LEN;
  localparam int NUM_BLOCKS      = 28;
  localparam int WATCHDOG_TIME   = NUM_BLOCKS * BLOCK_LEN * CLK_PERIOD * 2;

  logic    VCLK_i;
  logic    nVRST_i;
  vsync_t  sync_i;
  pix_t    pix_i;
  sl_cfg_t cfg_i;
  vsync_t  sync_o;
  pix_t    pix_o;

  logic [31:0] rand_state;
  vsync_t      exp_sync_q[$];  // one entry per driven cycle
  pix_t        exp_pix_q[$];

  task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  `include "tb_model.svh"

  scanline_emu_top uut (
    .VCLK_i  (VCLK_i),
    .nVRST_i (nVRST_i),
    .sync_i  (sync_i),
    .pix_i   (pix_i),
    .cfg_i   (cfg_i),
    .sync_o  (sync_o),
    .pix_o   (pix_o)
  );

  initial begin
    VCLK_i = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK_i = ~VCLK_i;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired at %0t, the test loop never finished", $time);
    stop_on_failure();
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic sl_cfg_t make_cfg(input logic en, input logic per_channel,
                                       input sl_thick_e thick, input logic [7:0] pos,
                                       input logic [7:0] strength, input logic [4:0] bloom);
    sl_cfg_t c;
    c.en          = en;
    c.per_channel = per_channel;
    c.thickness   = thick;
    c.rel_pos     = pos;
    c.strength    = strength;
    c.bloom       = bloom;
    return c;
  endfunction

  // corner cases first, then random
  function automatic sl_cfg_t block_cfg(input int blk);
    logic [31:0] r1;
    logic [31:0] r2;
    case (blk)
      0: return make_cfg(1'b1, 1'b1, SL_NORMAL, 8'd128, 8'd255, 5'd0);    // saturated max
      1: return make_cfg(1'b1, 1'b0, SL_ADAPTIVE, 8'd128, 8'd255, 5'd31);
      2: return make_cfg(1'b1, 1'b1, SL_THIN, 8'd2, 8'd200, 5'd10);      // no draw
      3: return make_cfg(1'b1, 1'b0, SL_THICK, 8'd254, 8'd180, 5'd20);   // folds to 2
      4: return make_cfg(1'b0, 1'b1, SL_THICK, 8'd100, 8'd255, 5'd5);    // scanlines off
      default: begin
        r1 = next_rand();
        r2 = next_rand();
        return make_cfg(r1[31:30] != 2'b00, r1[29], sl_thick_e'(r1[28:27]),
                        r2[31:24], r2[23:16], r2[15:11]);
      end
    endcase
  endfunction

  // drive one clock, queue the expected result and check at the falling edge
  task automatic drive_cycle(input vsync_t s, input pix_t p, input sl_cfg_t c);
    @(posedge VCLK_i);
    sync_i <= s;
    pix_i  <= p;
    cfg_i  <= c;
    exp_sync_q.push_back(s);
    exp_pix_q.push_back(expect_pix(p, s, c));
    @(negedge VCLK_i);
    if (exp_pix_q.size() > PROC_STAGES) begin
      check_sync("sync_o", sync_o, exp_sync_q.pop_front());
      check_pix("pix_o", pix_o, exp_pix_q.pop_front());
    end else begin
      check_sync("sync_o", sync_o, '0); // pipeline still holds reset data
      check_pix("pix_o", pix_o, '0);
    end
  endtask

  task automatic run_block(input sl_cfg_t c);
    logic [31:0] rs;
    logic [31:0] rp;
    vsync_t      s;
    pix_t        p;
    for (int i = 0; i < BLOCK_LEN; i++) begin
      rs      = next_rand();
      rp      = next_rand();
      s.hsync = rs[31];
      s.vsync = rs[30];
      s.de    = (i < ACT_LEN) && (rs[29:27] != 3'b000); // flush tail keeps DE low
      p.r     = rp[31:24];
      p.g     = rp[23:16];
      p.b     = rp[15:8];
      drive_cycle(s, p, c);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rand_state = 32'hfdb01e8a;
    nVRST_i    <= 1'b0;
    sync_i     <= '0;
    pix_i      <= '0;
    cfg_i      <= '0;

    repeat (RESET_CYCLES) begin
      @(negedge VCLK_i);
      check_sync("sync_o", sync_o, '0);
      check_pix("pix_o", pix_o, '0);
    end
    @(posedge VCLK_i);
    nVRST_i <= 1'b1;

    for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
      run_block(block_cfg(blk));
    end

    // drain what is still in flight
    while (exp_pix_q.size() > 0) begin
      @(negedge VCLK_i);
      check_sync("sync_o", sync_o, exp_sync_q.pop_front());
      check_pix("pix_o", pix_o, exp_pix_q.pop_front());
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
hw/sl_pkg.sv
hw/sl_timing_ctrl.sv
hw/sl_ref_gen.sv
hw/sl_strength_shaper.sv
hw/sl_bloom_mix.sv
hw/scanline_emu_top.sv
test/tb_scanline_emu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the scanline testbench with Verilator, run it and judge the log

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Mdir "$OBJ" --top-module tb_scanline_emu \
  -o tb_scanline_emu -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_scanline_emu" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "sim passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
